/* rtl/lake_pkg.sv */
package lake_pkg;

  parameter int data_w = 16;
  parameter int depth = 32;
  parameter int addr_w = $clog2(depth);  // 5 for 32 words
  parameter int cfg_w = 32;
  parameter int num_dims = 2;
  parameter int num_ports = 2;

  // one memory word
  typedef logic [data_w-1:0] data_t;

  // memory address
  typedef logic [addr_w-1:0] addr_t;

  // start, range and stride settings
  typedef logic [cfg_w-1:0] cfg_word_t;

  // number of active loop dimensions
  typedef logic [3:0] dim_t;

endpackage

/* rtl/addr_gen.sv */
module addr_gen #(
  parameter int num_dims = 2
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 step,
  input  lake_pkg::dim_t                       dimensionality,
  input  lake_pkg::cfg_word_t                  starting_addr,
  input  lake_pkg::cfg_word_t [num_dims-1:0]   ranges,
  input  lake_pkg::cfg_word_t [num_dims-1:0]   strides,
  output lake_pkg::addr_t                      addr
);
  import lake_pkg::*;

  cfg_word_t [num_dims-1:0] dim_cnt;
  cfg_word_t [num_dims-1:0] dim_off;
  logic [num_dims-1:0]      dim_wrap;
  logic [num_dims-1:0]      dim_adv;
  cfg_word_t                addr_full;

  always_comb begin
    logic carry;
    carry = step;
    for (int d = 0; d < num_dims; d++) begin
      dim_wrap[d] = (dim_cnt[d] == ranges[d] - cfg_word_t'(1));
      dim_adv[d] = carry && (d < int'(dimensionality));
      carry = carry & dim_wrap[d];  // next dim moves only on wrap
    end
  end

  always_comb begin
    addr_full = starting_addr;
    for (int d = 0; d < num_dims; d++) begin
      if (d < int'(dimensionality)) begin
        addr_full = addr_full + dim_off[d];
      end
    end
  end

  assign addr = addr_full[addr_w-1:0];  // truncate to memory range

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dim_cnt <= '0;
      dim_off <= '0;
    end else begin
      for (int d = 0; d < num_dims; d++) begin
        if (dim_adv[d]) begin
          if (dim_wrap[d]) begin
            dim_cnt[d] <= '0;
            dim_off[d] <= '0;
          end else begin
            dim_cnt[d] <= dim_cnt[d] + cfg_word_t'(1);
            dim_off[d] <= dim_off[d] + strides[d];
          end
        end
      end
    end
  end

endmodule

/* rtl/write_addr_ctrl.sv */
module write_addr_ctrl #(
  parameter int num_ports = 2
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic [num_ports-1:0]                                   wen,
  input  logic [num_ports-1:0]                                   wen_en,
  input  lake_pkg::data_t [num_ports-1:0]                        data_in,
  input  lake_pkg::dim_t [num_ports-1:0]                         dimensionality,
  input  lake_pkg::cfg_word_t [num_ports-1:0]                    starting_addr,
  input  lake_pkg::cfg_word_t [num_ports-1:0][lake_pkg::num_dims-1:0] ranges,
  input  lake_pkg::cfg_word_t [num_ports-1:0][lake_pkg::num_dims-1:0] strides,
  output logic [num_ports-1:0]                                   mem_wen,
  output lake_pkg::addr_t [num_ports-1:0]                        mem_wr_addr,
  output lake_pkg::data_t [num_ports-1:0]                        mem_wr_data
);
  import lake_pkg::*;

  logic [num_ports-1:0]  active;
  addr_t [num_ports-1:0] gen_addr;

  assign active = wen & wen_en;

  for (genvar s = 0; s < num_ports; s++) begin : g_gen
    addr_gen #(
      .num_dims(num_dims)
    ) u_addr_gen (
      .clk           (clk),
      .rst_n         (rst_n),
      .step          (active[s]),  // advance on each accepted write
      .dimensionality(dimensionality[s]),
      .starting_addr (starting_addr[s]),
      .ranges        (ranges[s]),
      .strides       (strides[s]),
      .addr          (gen_addr[s])
    );
  end

  // lowest active stream on port 0, next one on port 1
  always_comb begin
    int unsigned slot;
    slot = 0;
    mem_wen = '0;
    mem_wr_addr = '0;
    mem_wr_data = '0;
    for (int s = 0; s < num_ports; s++) begin
      if (active[s]) begin
        mem_wen[slot] = 1'b1;
        mem_wr_addr[slot] = gen_addr[s];
        mem_wr_data[slot] = data_in[s];
        slot++;
      end
    end
  end

endmodule

/* rtl/read_addr_ctrl.sv */
module read_addr_ctrl #(
  parameter int num_ports = 2
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic [num_ports-1:0]                                   rd_ack,
  input  lake_pkg::dim_t [num_ports-1:0]                         dimensionality,
  input  lake_pkg::cfg_word_t [num_ports-1:0]                    starting_addr,
  input  lake_pkg::cfg_word_t [num_ports-1:0][lake_pkg::num_dims-1:0] ranges,
  input  lake_pkg::cfg_word_t [num_ports-1:0][lake_pkg::num_dims-1:0] strides,
  output lake_pkg::addr_t [num_ports-1:0]                        rd_addr
);
  import lake_pkg::*;

  // address moves on only once the current word has been served
  for (genvar s = 0; s < num_ports; s++) begin : g_gen
    addr_gen #(
      .num_dims(num_dims)
    ) u_addr_gen (
      .clk           (clk),
      .rst_n         (rst_n),
      .step          (rd_ack[s]),
      .dimensionality(dimensionality[s]),
      .starting_addr (starting_addr[s]),
      .ranges        (ranges[s]),
      .strides       (strides[s]),
      .addr          (rd_addr[s])
    );
  end

endmodule

/* rtl/read_arbiter.sv */
module read_arbiter #(
  parameter int num_ports = 2
) (
  input  logic [num_ports-1:0]            ren,
  input  logic [num_ports-1:0]            ren_en,
  input  lake_pkg::addr_t [num_ports-1:0] rd_addr,
  input  lake_pkg::data_t [num_ports-1:0] mem_rd_data,
  output lake_pkg::addr_t [num_ports-1:0] mem_rd_addr,
  output logic [num_ports-1:0]            rd_ack,
  output logic [num_ports-1:0]            valid_out,
  output lake_pkg::data_t [num_ports-1:0] data_out
);
  import lake_pkg::*;

  logic [num_ports-1:0]                req;
  logic [num_ports-1:0][num_ports-1:0] port_owner;  // one-hot stream per port

  assign req = ren & ren_en;

  // same packing rule as the write side
  always_comb begin
    int unsigned slot;
    slot = 0;
    port_owner = '0;
    mem_rd_addr = '0;
    for (int s = 0; s < num_ports; s++) begin
      if (req[s]) begin
        port_owner[slot][s] = 1'b1;
        mem_rd_addr[slot] = rd_addr[s];
        slot++;
      end
    end
  end

  // route port data back to the stream that owns it
  always_comb begin
    rd_ack = '0;
    valid_out = '0;
    data_out = '0;
    for (int s = 0; s < num_ports; s++) begin
      for (int p = 0; p < num_ports; p++) begin
        if (port_owner[p][s]) begin
          rd_ack[s] = 1'b1;
          valid_out[s] = 1'b1;
          data_out[s] = mem_rd_data[p];
        end
      end
    end
  end

endmodule

/* rtl/tile_storage.sv */
module tile_storage #(
  parameter int num_ports = 2,
  parameter int depth = 32,
  parameter int data_w = 16
) (
  input  logic                            clk,
  input  logic [num_ports-1:0]            mem_wen,
  input  lake_pkg::addr_t [num_ports-1:0] mem_wr_addr,
  input  lake_pkg::data_t [num_ports-1:0] mem_wr_data,
  input  lake_pkg::addr_t [num_ports-1:0] mem_rd_addr,
  input  logic                            config_en,
  input  logic                            config_write,
  input  logic [7:0]                      config_addr_in,
  input  lake_pkg::data_t                 config_data_in,
  output lake_pkg::data_t [num_ports-1:0] mem_rd_data,
  output lake_pkg::data_t                 config_data_out
);
  import lake_pkg::*;

  logic [data_w-1:0]     mem [depth];
  logic [num_ports-1:0]  wr_en;
  addr_t [num_ports-1:0] wr_addr;
  data_t [num_ports-1:0] wr_data;
  addr_t [num_ports-1:0] rd_addr;

  // host takes over port 0 in both directions
  always_comb begin
    wr_en = mem_wen;
    wr_addr = mem_wr_addr;
    wr_data = mem_wr_data;
    rd_addr = mem_rd_addr;
    if (config_en) begin
      wr_en[0] = config_write;
      wr_addr[0] = config_addr_in[addr_w-1:0];
      wr_data[0] = config_data_in;
      rd_addr[0] = config_addr_in[addr_w-1:0];
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < num_ports; p++) begin
      if (wr_en[p]) begin
        mem[wr_addr[p]] <= wr_data[p];  // higher port wins on collision
      end
    end
  end

  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      mem_rd_data[p] = mem[rd_addr[p]];
    end
  end

  assign config_data_out = mem_rd_data[0];

endmodule

/* rtl/lake_top.sv */
module lake_top #(
  parameter int num_ports = lake_pkg::num_ports,
  parameter int depth = lake_pkg::depth,
  parameter int data_w = lake_pkg::data_w
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [num_ports-1:0]                          wen,
  input  logic [num_ports-1:0]                          wen_en,
  input  lake_pkg::data_t [num_ports-1:0]               data_in,
  input  logic [num_ports-1:0]                          ren,
  input  logic [num_ports-1:0]                          ren_en,
  output logic [num_ports-1:0]                          valid_out,
  output lake_pkg::data_t [num_ports-1:0]               data_out,
  input  logic                                          config_en,
  input  logic                                          config_write,
  input  logic [7:0]                                    config_addr_in,
  input  lake_pkg::data_t                               config_data_in,
  output lake_pkg::data_t                               config_data_out,
  input  lake_pkg::dim_t                                input_gen_0_dimensionality,
  input  lake_pkg::cfg_word_t                           input_gen_0_starting_addr,
  input  lake_pkg::cfg_word_t [lake_pkg::num_dims-1:0]  input_gen_0_ranges,
  input  lake_pkg::cfg_word_t [lake_pkg::num_dims-1:0]  input_gen_0_strides,
  input  lake_pkg::dim_t                                input_gen_1_dimensionality,
  input  lake_pkg::cfg_word_t                           input_gen_1_starting_addr,
  input  lake_pkg::cfg_word_t [lake_pkg::num_dims-1:0]  input_gen_1_ranges,
  input  lake_pkg::cfg_word_t [lake_pkg::num_dims-1:0]  input_gen_1_strides,
  input  lake_pkg::dim_t                                output_gen_0_dimensionality,
  input  lake_pkg::cfg_word_t                           output_gen_0_starting_addr,
  input  lake_pkg::cfg_word_t [lake_pkg::num_dims-1:0]  output_gen_0_ranges,
  input  lake_pkg::cfg_word_t [lake_pkg::num_dims-1:0]  output_gen_0_strides,
  input  lake_pkg::dim_t                                output_gen_1_dimensionality,
  input  lake_pkg::cfg_word_t                           output_gen_1_starting_addr,
  input  lake_pkg::cfg_word_t [lake_pkg::num_dims-1:0]  output_gen_1_ranges,
  input  lake_pkg::cfg_word_t [lake_pkg::num_dims-1:0]  output_gen_1_strides
);
  import lake_pkg::*;

  logic [num_ports-1:0]  mem_wen;
  addr_t [num_ports-1:0] mem_wr_addr;
  data_t [num_ports-1:0] mem_wr_data;
  addr_t [num_ports-1:0] rd_addr;
  logic [num_ports-1:0]  rd_ack;
  addr_t [num_ports-1:0] mem_rd_addr;
  data_t [num_ports-1:0] mem_rd_data;

  write_addr_ctrl #(
    .num_ports(num_ports)
  ) u_write_addr_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .wen           (wen),
    .wen_en        (wen_en),
    .data_in       (data_in),
    .dimensionality({input_gen_1_dimensionality, input_gen_0_dimensionality}),
    .starting_addr ({input_gen_1_starting_addr, input_gen_0_starting_addr}),
    .ranges        ({input_gen_1_ranges, input_gen_0_ranges}),
    .strides       ({input_gen_1_strides, input_gen_0_strides}),
    .mem_wen       (mem_wen),
    .mem_wr_addr   (mem_wr_addr),
    .mem_wr_data   (mem_wr_data)
  );

  read_addr_ctrl #(
    .num_ports(num_ports)
  ) u_read_addr_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_ack        (rd_ack),
    .dimensionality({output_gen_1_dimensionality, output_gen_0_dimensionality}),
    .starting_addr ({output_gen_1_starting_addr, output_gen_0_starting_addr}),
    .ranges        ({output_gen_1_ranges, output_gen_0_ranges}),
    .strides       ({output_gen_1_strides, output_gen_0_strides}),
    .rd_addr       (rd_addr)
  );

  read_arbiter #(
    .num_ports(num_ports)
  ) u_read_arbiter (
    .ren        (ren),
    .ren_en     (ren_en),
    .rd_addr    (rd_addr),
    .mem_rd_data(mem_rd_data),
    .mem_rd_addr(mem_rd_addr),
    .rd_ack     (rd_ack),
    .valid_out  (valid_out),
    .data_out   (data_out)
  );

  tile_storage #(
    .num_ports(num_ports),
    .depth    (depth),
    .data_w   (data_w)
  ) u_tile_storage (
    .clk            (clk),
    .mem_wen        (mem_wen),
    .mem_wr_addr    (mem_wr_addr),
    .mem_wr_data    (mem_wr_data),
    .mem_rd_addr    (mem_rd_addr),
    .config_en      (config_en),
    .config_write   (config_write),
    .config_addr_in (config_addr_in),
    .config_data_in (config_data_in),
    .mem_rd_data    (mem_rd_data),
    .config_data_out(config_data_out)
  );

endmodule

/* tests/lake_top_sva.sv */
module lake_top_sva (
  input logic                                          clk,
  input logic                                          rst_n,
  input logic [lake_pkg::num_ports-1:0]                wen,
  input logic [lake_pkg::num_ports-1:0]                wen_en,
  input lake_pkg::data_t [lake_pkg::num_ports-1:0]     data_in,
  input logic [lake_pkg::num_ports-1:0]                ren,
  input logic [lake_pkg::num_ports-1:0]                ren_en,
  input logic [lake_pkg::num_ports-1:0]                valid_out,
  input lake_pkg::data_t [lake_pkg::num_ports-1:0]     data_out,
  input logic                                          config_en,
  input logic                                          config_write,
  input logic [7:0]                                    config_addr_in,
  input lake_pkg::data_t                               config_data_in,
  input lake_pkg::data_t                               config_data_out,
  input lake_pkg::dim_t [3:0]                          gen_dim,  // in0, in1, out0, out1
  input lake_pkg::cfg_word_t [3:0]                     gen_start,
  input lake_pkg::cfg_word_t [3:0][lake_pkg::num_dims-1:0] gen_range,
  input lake_pkg::cfg_word_t [3:0][lake_pkg::num_dims-1:0] gen_stride
);
  import lake_pkg::*;

  data_t                         shadow [depth];
  cfg_word_t [3:0][num_dims-1:0] m_cnt;
  cfg_word_t [3:0][num_dims-1:0] m_off;
  addr_t [3:0]                   m_addr;
  logic [3:0]                    m_step;
  data_t [num_ports-1:0]         exp_rd;
  data_t                         exp_cfg;
  string                         err_name;
  logic [31:0]                   err_got;
  logic [31:0]                   err_exp;
  logic                          failed = 1'b0;

  task automatic record_error(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    err_name = name;
    err_got = got;
    err_exp = exp;
    failed = 1'b1;
  endtask

  assign m_step = {ren & ren_en, wen & wen_en};

  always_comb begin
    cfg_word_t sum;
    for (int g = 0; g < 4; g++) begin
      sum = gen_start[g];
      if (gen_dim[g] >= 1) sum = sum + m_off[g][0];
      if (gen_dim[g] >= 2) sum = sum + m_off[g][1];
      m_addr[g] = sum[addr_w-1:0];
    end
  end

  // outer loop ticks when the inner one rolls over
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_cnt <= '0;
      m_off <= '0;
    end else begin
      for (int g = 0; g < 4; g++) begin
        if (m_step[g] && gen_dim[g] >= 1) begin
          if (m_cnt[g][0] == gen_range[g][0] - 1) begin
            m_cnt[g][0] <= '0;
            m_off[g][0] <= '0;
            if (gen_dim[g] >= 2) begin
              if (m_cnt[g][1] == gen_range[g][1] - 1) begin
                m_cnt[g][1] <= '0;
                m_off[g][1] <= '0;
              end else begin
                m_cnt[g][1] <= m_cnt[g][1] + 1;
                m_off[g][1] <= m_off[g][1] + gen_stride[g][1];
              end
            end
          end else begin
            m_cnt[g][0] <= m_cnt[g][0] + 1;
            m_off[g][0] <= m_off[g][0] + gen_stride[g][0];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (config_en) begin
      if (config_write) shadow[config_addr_in[addr_w-1:0]] <= config_data_in;
    end else begin
      for (int s = 0; s < num_ports; s++) begin
        if (m_step[s]) shadow[m_addr[s]] <= data_in[s];  // stream 1 last, so it wins
      end
    end
  end

  assign exp_rd[0] = shadow[m_addr[2]];
  assign exp_rd[1] = shadow[m_addr[3]];
  assign exp_cfg = shadow[config_addr_in[addr_w-1:0]];

  a_valid_req: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out == (ren & ren_en))
    else begin
      record_error("valid_out", $sampled(valid_out), $sampled(ren & ren_en));
      $error("valid_out does not follow the read request");
    end

  a_cfg_read: assert property (@(posedge clk) disable iff (!rst_n)
    config_en && !config_write |-> config_data_out == exp_cfg)
    else begin
      record_error("config_data_out", $sampled(config_data_out), $sampled(exp_cfg));
      $error("config readback differs from shadow memory");
    end

  a_read_0: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out[0] && !config_en |-> data_out[0] == exp_rd[0])
    else begin
      record_error("data_out[0]", $sampled(data_out[0]), $sampled(exp_rd[0]));
      $error("stream 0 read data differs from shadow memory");
    end

  a_read_1: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out[1] && !config_en |-> data_out[1] == exp_rd[1])
    else begin
      record_error("data_out[1]", $sampled(data_out[1]), $sampled(exp_rd[1]));
      $error("stream 1 read data differs from shadow memory");
    end

endmodule

/* tests/lake_top_tb.sv */
module lake_top_tb;
  import lake_pkg::*;

  localparam int clk_period = 10;
  localparam int n_wr2d = 40;
  localparam int n_dual = 24;
  localparam int n_align = 13;
  localparam int n_rd = 60;
  localparam int total_cycles = 4 + 4 + 4 * depth + n_wr2d + n_dual + n_align + n_rd + 2;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic [num_ports-1:0]     wen, wen_en, ren, ren_en, valid_out;
  data_t [num_ports-1:0]    data_in, data_out;
  logic                     config_en, config_write;
  logic [7:0]               config_addr_in;
  data_t                    config_data_in, config_data_out;
  dim_t                     input_gen_0_dimensionality, input_gen_1_dimensionality;
  dim_t                     output_gen_0_dimensionality, output_gen_1_dimensionality;
  cfg_word_t                input_gen_0_starting_addr, input_gen_1_starting_addr;
  cfg_word_t                output_gen_0_starting_addr, output_gen_1_starting_addr;
  cfg_word_t [num_dims-1:0] input_gen_0_ranges, input_gen_1_ranges;
  cfg_word_t [num_dims-1:0] output_gen_0_ranges, output_gen_1_ranges;
  cfg_word_t [num_dims-1:0] input_gen_0_strides, input_gen_1_strides;
  cfg_word_t [num_dims-1:0] output_gen_0_strides, output_gen_1_strides;
  logic [31:0]              rng = 32'h98236a43;

  lake_top u_lake_top (.*);

  bind lake_top lake_top_sva u_sva (
    .clk, .rst_n, .wen, .wen_en, .data_in, .ren, .ren_en, .valid_out, .data_out,
    .config_en, .config_write, .config_addr_in, .config_data_in, .config_data_out,
    .gen_dim   ({output_gen_1_dimensionality, output_gen_0_dimensionality,
                 input_gen_1_dimensionality, input_gen_0_dimensionality}),
    .gen_start ({output_gen_1_starting_addr, output_gen_0_starting_addr,
                 input_gen_1_starting_addr, input_gen_0_starting_addr}),
    .gen_range ({output_gen_1_ranges, output_gen_0_ranges,
                 input_gen_1_ranges, input_gen_0_ranges}),
    .gen_stride({output_gen_1_strides, output_gen_0_strides,
                 input_gen_1_strides, input_gen_0_strides})
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic cfg_readback();
    for (int a = 0; a < depth; a++) begin
      config_en = 1'b1;
      config_write = 1'b0;
      config_addr_in = 8'(a);
      tick();
    end
    config_en = 1'b0;
  endtask

  initial begin : fail_watch
    wait (u_lake_top.u_sva.failed === 1'b1);
    $display("** Error %s: got 0x%0h, expected 0x%0h", u_lake_top.u_sva.err_name,
             u_lake_top.u_sva.err_got, u_lake_top.u_sva.err_exp);
    $display("TEST FAILED");
    $fatal(1, "an assertion check failed");
  end

  initial begin : watchdog
    #(2 * total_cycles * clk_period);
    $display("watchdog expired before all test phases finished");
    $display("TEST FAILED");
    $fatal(1, "simulation timeout");
  end

  initial begin
    rst_n = 1'b0;
    {wen, wen_en, ren, ren_en, data_in} = '0;
    {config_en, config_write, config_addr_in, config_data_in} = '0;
    input_gen_0_dimensionality = 4'd2;  // 0..3, 8..11, 16..19
    input_gen_0_starting_addr = 32'd0;
    input_gen_0_ranges = {32'd3, 32'd4};
    input_gen_0_strides = {32'd8, 32'd1};
    input_gen_1_dimensionality = 4'd0;  // fixed at 9 and meets stream 0 once per lap
    input_gen_1_starting_addr = 32'd9;
    input_gen_1_ranges = '0;
    input_gen_1_strides = '0;
    output_gen_0_dimensionality = 4'd2;
    output_gen_0_starting_addr = 32'd0;
    output_gen_0_ranges = {32'd4, 32'd8};
    output_gen_0_strides = {32'd8, 32'd1};
    output_gen_1_dimensionality = 4'd2;
    output_gen_1_starting_addr = 32'd35;  // wraps to 3
    output_gen_1_ranges = {32'd3, 32'd5};
    output_gen_1_strides = {32'd7, 32'd3};
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (4) tick();
    for (int a = 0; a < depth; a++) begin
      rng = xorshift(rng);
      config_en = 1'b1;
      config_write = 1'b1;
      config_addr_in = 8'(a);
      config_data_in = rng[15:0];
      tick();
    end
    config_write = 1'b0;
    cfg_readback();
    repeat (n_wr2d) begin
      rng = xorshift(rng);
      wen[0] = rng[0];
      wen_en[0] = rng[1];
      data_in[0] = rng[31:16];
      tick();
    end
    wen = '0;
    wen_en = '0;
    cfg_readback();
    repeat (n_dual) begin
      rng = xorshift(rng);
      wen = 2'b11;
      wen_en = 2'b11;
      data_in[0] = rng[15:0];
      data_in[1] = rng[31:16];
      tick();
    end
    wen = 2'b01;
    wen_en = 2'b01;
    for (int i = 0; i < n_align - 1 && u_lake_top.u_sva.m_addr[0] != addr_t'(9); i++) begin
      rng = xorshift(rng);
      data_in[0] = rng[15:0];
      tick();
    end
    rng = xorshift(rng);  // both streams on address 9
    wen = 2'b11;
    wen_en = 2'b11;
    data_in[0] = rng[15:0];
    data_in[1] = rng[31:16];
    tick();
    wen = '0;
    wen_en = '0;
    cfg_readback();
    repeat (n_rd) begin
      rng = xorshift(rng);
      ren = rng[1:0];
      ren_en = rng[3:2];
      tick();
    end
    ren = '0;
    ren_en = '0;
    tick();
    if (u_lake_top.u_sva.failed) begin
      $display("TEST FAILED");
      $fatal(1, "an assertion check failed");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

/* sources.f */
rtl/lake_pkg.sv
rtl/addr_gen.sv
rtl/write_addr_ctrl.sv
rtl/read_addr_ctrl.sv
rtl/read_arbiter.sv
rtl/tile_storage.sv
rtl/lake_top.sv
tests/lake_top_sva.sv
tests/lake_top_tb.sv
